/* board_defines.svh */
// Board shell constants for reset delay, display scan rate and pad synchronizer depth
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// Reset sanity count, cycles of clock_50mhz after reset pin release
`define RST_SANITY_COUNT 16'hAA55

// Cycles spent on each display digit
`define SEG_SCAN_DIV 250 // 200 kHz digit rate at 50 MHz

// Flip-flops per pad input synchronizer
`define SYNC_STAGES 2

`endif

/* board_pkg.sv */
// Board shell package with the shared vector types and the reset sequencer states
`default_nettype none

package board_pkg;

	typedef logic [15:0] rst_count_t; // Reset sanity counter value
	typedef logic [15:0] scan_count_t; // Display scan divider value

	typedef logic [3:0] sd_pad_t; // SD card DAT0..DAT3

	typedef logic [7:0] seg_char_t; // Digit select, active low
	typedef logic [7:0] seg_seg_t; // {dp, g, f, e, d, c, b, a}, active low

	typedef logic [31:0] hex_word_t; // Status word, eight nibbles
	typedef logic [2:0] digit_idx_t; // Digit being scanned

	// Reset release sequence
	typedef enum logic [1:0]
	{
		RST_HOLD,
		RST_COUNT,
		RST_SETTLE,
		RST_RUN
	} rst_state_t;

endpackage

`default_nettype wire

/* board_ifs.sv */
// Board shell interfaces for the delay timer control and the core-to-pad signal bundle
`timescale 1ns/1ps
`default_nettype none

interface timer_if #(parameter int WIDTH = 16);

	logic clear; // Zero the count
	logic run; // Count enable
	logic [WIDTH-1:0] count;
	logic done; // Count at terminal value

	// Sequencer side
	modport ctrl
	(
		output clear,
		output run,
		input count,
		input done
	);

	// Counter side
	modport cnt
	(
		input clear,
		input run,
		output count,
		output done
	);

endinterface

interface pad_if;
	import board_pkg::*;

	logic ps2_clk_val; // Core PS/2 clock drive value
	logic ps2_clk_drv; // Core PS/2 clock drive enable
	logic ps2_data_val;
	logic ps2_data_drv;
	sd_pad_t sdc_val;
	sd_pad_t sdc_drv;
	logic aud_bit; // 0 pulls the audio line low

	// Synchronized pad levels back to the core
	logic ps2_clk_sync;
	logic ps2_data_sync;
	sd_pad_t sdc_sync;

	modport core
	(
		output ps2_clk_val, ps2_clk_drv, ps2_data_val, ps2_data_drv,
		output sdc_val, sdc_drv, aud_bit,
		input ps2_clk_sync, ps2_data_sync, sdc_sync
	);

	modport pad
	(
		input ps2_clk_val, ps2_clk_drv, ps2_data_val, ps2_data_drv,
		input sdc_val, sdc_drv, aud_bit,
		output ps2_clk_sync, ps2_data_sync, sdc_sync
	);

endinterface

`default_nettype wire

/* delay_timer.sv */
// Delay timer, up-counter with clear, run enable and a registered terminal-count flag
`timescale 1ns/1ps
`default_nettype none

module delay_timer #(
	parameter int WIDTH = 16
) (
	input logic clock_50mhz,
	input logic reset2a,
	input logic [WIDTH-1:0] terminal_i, // Count holds here
	timer_if.cnt tmr
);

	logic [WIDTH-1:0] count_q;
	logic [WIDTH-1:0] count_d;
	logic done_q;

	// Clear wins over run, stop at terminal
	always_comb
	begin
		count_d = count_q;
		if (tmr.clear)
			count_d = '0;
		else if (tmr.run && (count_q != terminal_i))
			count_d = count_q + 1'b1;
	end

	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			count_q <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			count_q <= count_d;
			done_q <= (count_d == terminal_i); // Flag lines up with the count
		end
	end

	assign tmr.count = count_q;
	assign tmr.done = done_q;

	// Count must never run past the terminal value
	a_count_bound: assert property (@(posedge clock_50mhz) disable iff (reset2a)
		tmr.count <= terminal_i);

endmodule

`default_nettype wire

/* reset_seq_fsm.sv */
// Reset sequencer FSM, holds the core in reset until the sanity count has run out
`timescale 1ns/1ps
`default_nettype none

module reset_seq_fsm (
	input logic clock_50mhz,
	input logic reset2a, // Pin reset, already inverted
	timer_if.ctrl tmr,
	output logic core_reset_o
);
	import board_pkg::*;

	rst_state_t state_q;
	rst_state_t state_d;
	logic core_reset_q;

	// Next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			RST_HOLD:
				state_d = RST_COUNT; // First cycle after pin release
			RST_COUNT:
			begin
				if (tmr.done)
					state_d = RST_SETTLE;
			end
			RST_SETTLE:
				state_d = RST_RUN; // One spare cycle
			RST_RUN:
				state_d = RST_RUN; // Only reset2a leaves
			default:
				state_d = RST_HOLD;
		endcase
	end

	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			state_q <= RST_HOLD;
			core_reset_q <= 1'b1;
		end
		else
		begin
			state_q <= state_d;
			core_reset_q <= (state_q != RST_RUN); // Registered release stage
		end
	end

	// Timer zeroed while holding, counts in RST_COUNT
	assign tmr.clear = (state_q == RST_HOLD);
	assign tmr.run = (state_q == RST_COUNT);

	assign core_reset_o = core_reset_q;

	// Pin reset reaches the core on the next edge
	a_reset_follow: assert property (@(posedge clock_50mhz)
		reset2a |=> core_reset_o);

	// Running state is sticky
	a_run_sticky: assert property (@(posedge clock_50mhz)
		(state_q == RST_RUN) && !reset2a |=> (state_q == RST_RUN));

endmodule

`default_nettype wire

/* pad_bank.sv */
// Pad bank, gates the PS/2, SD and audio drivers and synchronizes the pad levels
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module pad_bank (
	input logic clock_50mhz,
	input logic reset2a,
	input logic core_reset_i, // Drivers off while high
	pad_if.pad pads,
	output logic ps2_clk_oe_o,
	output logic ps2_clk_val_o,
	output logic ps2_data_oe_o,
	output logic ps2_data_val_o,
	output board_pkg::sd_pad_t sdc_oe_o,
	output board_pkg::sd_pad_t sdc_val_o,
	output logic aud_oe_o, // Pulls the audio line low
	input logic ps2_clk_pad_i, // Resolved pad levels
	input logic ps2_data_pad_i,
	input board_pkg::sd_pad_t sdc_dat_pad_i
);
	import board_pkg::*;

	localparam int SYNC_W = 2 + $bits(sd_pad_t); // PS/2 clock, PS/2 data, SD data

	logic drive_ok;
	logic [SYNC_W-1:0] pad_level;
	logic [SYNC_W-1:0] sync_q [`SYNC_STAGES];

	assign drive_ok = ~core_reset_i;

	// Output enables, combinational from the core
	assign ps2_clk_oe_o = pads.ps2_clk_drv & drive_ok;
	assign ps2_data_oe_o = pads.ps2_data_drv & drive_ok;
	assign sdc_oe_o = pads.sdc_drv & {$bits(sd_pad_t){drive_ok}};

	// Drive values pass straight through, oe decides
	assign ps2_clk_val_o = pads.ps2_clk_val;
	assign ps2_data_val_o = pads.ps2_data_val;
	assign sdc_val_o = pads.sdc_val;

	// Open drain audio, low when the bit is 0, released when 1
	assign aud_oe_o = ~pads.aud_bit & drive_ok;

	assign pad_level = {ps2_clk_pad_i, ps2_data_pad_i, sdc_dat_pad_i};

	// Synchronizer chain, presets to the idle pulled-up level
	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
		begin
			for (int i = 0; i < `SYNC_STAGES; i++)
				sync_q[i] <= '1;
		end
		else
		begin
			sync_q[0] <= pad_level;
			for (int i = 1; i < `SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	// Last stage back to the core
	assign pads.ps2_clk_sync = sync_q[`SYNC_STAGES-1][SYNC_W-1];
	assign pads.ps2_data_sync = sync_q[`SYNC_STAGES-1][SYNC_W-2];
	assign pads.sdc_sync = sync_q[`SYNC_STAGES-1][$bits(sd_pad_t)-1:0];

	// No driver may be on while the sequencer holds the core in reset
	a_no_drive_in_reset: assert property (@(posedge clock_50mhz)
		core_reset_i |-> !(ps2_clk_oe_o || ps2_data_oe_o || (|sdc_oe_o) || aud_oe_o));

endmodule

`default_nettype wire

/* seg_scanner.sv */
// Seven-segment scanner, multiplexes eight hex digits of the status word onto the display
`timescale 1ns/1ps
`default_nettype none

module seg_scanner (
	input logic clock_50mhz,
	input logic reset2a,
	input logic core_reset_i, // Display blank while high
	input logic tick_i, // One cycle per digit period
	input board_pkg::hex_word_t status_word_i,
	output board_pkg::seg_char_t seg_char_o,
	output board_pkg::seg_seg_t seg_seg_o
);
	import board_pkg::*;

	digit_idx_t digit_q;
	logic [3:0] nibble;
	seg_char_t char_q;
	seg_seg_t seg_q;

	// Hex to segments, active low, dp off in bit 7
	function automatic seg_seg_t hex_to_seg(input logic [3:0] hex);
		seg_seg_t seg;
		case (hex)
			4'h0: seg = 8'hC0;
			4'h1: seg = 8'hF9;
			4'h2: seg = 8'hA4;
			4'h3: seg = 8'hB0;
			4'h4: seg = 8'h99;
			4'h5: seg = 8'h92;
			4'h6: seg = 8'h82;
			4'h7: seg = 8'hF8;
			4'h8: seg = 8'h80;
			4'h9: seg = 8'h90;
			4'hA: seg = 8'h88;
			4'hB: seg = 8'h83; // Lower case b
			4'hC: seg = 8'hC6;
			4'hD: seg = 8'hA1; // Lower case d
			4'hE: seg = 8'h86;
			default: seg = 8'h8E; // F
		endcase
		return seg;
	endfunction

	// Digit d shows bits 4d+3 down to 4d
	assign nibble = status_word_i[{digit_q, 2'b00} +: 4];

	// Digit index steps once per tick
	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
			digit_q <= '0;
		else if (tick_i)
			digit_q <= digit_q + 1'b1;
	end

	// Registered outputs, one cycle behind the index
	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a || core_reset_i)
		begin
			char_q <= '1; // All digits off
			seg_q <= '1;
		end
		else
		begin
			char_q <= seg_char_t'(~(8'h01 << digit_q)); // Single low select bit
			seg_q <= hex_to_seg(nibble);
		end
	end

	assign seg_char_o = char_q;
	assign seg_seg_o = seg_q;

	// Never more than one digit selected
	a_one_digit: assert property (@(posedge clock_50mhz) disable iff (reset2a)
		$onehot0(~seg_char_o));

endmodule

`default_nettype wire

/* board_top.sv */
// Board I/O shell top level, ties pins and core-side ports to reset, pad and display blocks
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module board_top (
	input logic clock_50mhz,
	input logic reset2a_i, // Active high pin reset
	// Core side
	input logic core_ps2_clk_val_i,
	input logic core_ps2_clk_drv_i,
	input logic core_ps2_data_val_i,
	input logic core_ps2_data_drv_i,
	input board_pkg::sd_pad_t core_sdc_val_i,
	input board_pkg::sd_pad_t core_sdc_drv_i,
	input logic core_aud_i,
	input board_pkg::hex_word_t status_word_i,
	// Resolved pad levels
	input logic ps2_clk_pad_i,
	input logic ps2_data_pad_i,
	input board_pkg::sd_pad_t sdc_dat_pad_i,
	output logic core_reset_o,
	// Synchronized levels to the core
	output logic ps2_clk_sync_o,
	output logic ps2_data_sync_o,
	output board_pkg::sd_pad_t sdc_dat_sync_o,
	// Pad drivers
	output logic ps2_clk_oe_o,
	output logic ps2_clk_val_o,
	output logic ps2_data_oe_o,
	output logic ps2_data_val_o,
	output board_pkg::sd_pad_t sdc_oe_o,
	output board_pkg::sd_pad_t sdc_val_o,
	output logic aud_oe_o,
	output board_pkg::seg_char_t seg_char_o,
	output board_pkg::seg_seg_t seg_seg_o
);
	import board_pkg::*;

	localparam rst_count_t RST_TERM = rst_count_t'(`RST_SANITY_COUNT);
	localparam scan_count_t SCAN_TERM = scan_count_t'(`SEG_SCAN_DIV - 1); // Wraps every DIV

	logic core_reset;

	timer_if #(.WIDTH($bits(rst_count_t))) rst_tmr ();
	timer_if #(.WIDTH($bits(scan_count_t))) scan_tmr ();
	pad_if pad_bus ();

	// Core side of the pad bundle
	assign pad_bus.ps2_clk_val = core_ps2_clk_val_i;
	assign pad_bus.ps2_clk_drv = core_ps2_clk_drv_i;
	assign pad_bus.ps2_data_val = core_ps2_data_val_i;
	assign pad_bus.ps2_data_drv = core_ps2_data_drv_i;
	assign pad_bus.sdc_val = core_sdc_val_i;
	assign pad_bus.sdc_drv = core_sdc_drv_i;
	assign pad_bus.aud_bit = core_aud_i;
	assign ps2_clk_sync_o = pad_bus.ps2_clk_sync;
	assign ps2_data_sync_o = pad_bus.ps2_data_sync;
	assign sdc_dat_sync_o = pad_bus.sdc_sync;

	// Scan divider restarts itself, runs once the core is out of reset
	assign scan_tmr.clear = scan_tmr.done;
	assign scan_tmr.run = ~core_reset;

	reset_seq_fsm i_reset_seq_fsm (
		.clock_50mhz (clock_50mhz),
		.reset2a (reset2a_i),
		.tmr (rst_tmr.ctrl),
		.core_reset_o (core_reset)
	);

	delay_timer #(.WIDTH($bits(rst_count_t))) rst_timer (
		.clock_50mhz (clock_50mhz),
		.reset2a (reset2a_i),
		.terminal_i (RST_TERM),
		.tmr (rst_tmr.cnt)
	);

	delay_timer #(.WIDTH($bits(scan_count_t))) scan_timer (
		.clock_50mhz (clock_50mhz),
		.reset2a (reset2a_i),
		.terminal_i (SCAN_TERM),
		.tmr (scan_tmr.cnt)
	);

	pad_bank i_pad_bank (
		.clock_50mhz (clock_50mhz),
		.reset2a (reset2a_i),
		.core_reset_i (core_reset),
		.pads (pad_bus.pad),
		.ps2_clk_oe_o (ps2_clk_oe_o),
		.ps2_clk_val_o (ps2_clk_val_o),
		.ps2_data_oe_o (ps2_data_oe_o),
		.ps2_data_val_o (ps2_data_val_o),
		.sdc_oe_o (sdc_oe_o),
		.sdc_val_o (sdc_val_o),
		.aud_oe_o (aud_oe_o),
		.ps2_clk_pad_i (ps2_clk_pad_i),
		.ps2_data_pad_i (ps2_data_pad_i),
		.sdc_dat_pad_i (sdc_dat_pad_i)
	);

	seg_scanner i_seg_scanner (
		.clock_50mhz (clock_50mhz),
		.reset2a (reset2a_i),
		.core_reset_i (core_reset),
		.tick_i (scan_tmr.done), // One pulse per digit period
		.status_word_i (status_word_i),
		.seg_char_o (seg_char_o),
		.seg_seg_o (seg_seg_o)
	);

	assign core_reset_o = core_reset;

endmodule

`default_nettype wire

/* tb_board_top.sv */
// Testbench for the board I/O shell, resolves the pads, checks by assertions, ends by watchdog
`timescale 1ns/1ps
`default_nettype none
`include "board_defines.svh"

module tb_board_top;
	import board_pkg::*;

	localparam int RST_N = int'(`RST_SANITY_COUNT);
	localparam int SCAN_DIV = `SEG_SCAN_DIV;
	localparam int SYNC_N = `SYNC_STAGES;
	localparam int WATCHDOG_CYCLES = RST_N + 40 * SCAN_DIV + 1000;

	// Lit segments gfedcba for 0..F, active high
	localparam logic [6:0] SEG_ON [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D,
		7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

	logic clock_50mhz = 1'b0;
	logic reset2a_i;
	logic core_ps2_clk_val_i, core_ps2_clk_drv_i;
	logic core_ps2_data_val_i, core_ps2_data_drv_i;
	sd_pad_t core_sdc_val_i, core_sdc_drv_i;
	logic core_aud_i;
	hex_word_t status_word_i;
	logic ps2_clk_pad, ps2_data_pad; // Resolved lines
	sd_pad_t sdc_pad;
	logic core_reset_o, ps2_clk_sync_o, ps2_data_sync_o;
	sd_pad_t sdc_dat_sync_o;
	logic ps2_clk_oe_o, ps2_clk_val_o, ps2_data_oe_o, ps2_data_val_o;
	sd_pad_t sdc_oe_o, sdc_val_o;
	logic aud_oe_o;
	seg_char_t seg_char_o;
	seg_seg_t seg_seg_o;

	integer seed = 32'h51405d15;
	int errors = 0;
	int tests_run = 0;
	int since_rel = 0; // Edges seen with reset2a_i low
	logic rst_seen = 1'b0;
	logic [7:0] seen; // Digits scanned so far
	int mark;

	always #10 clock_50mhz = ~clock_50mhz; // 50 MHz

	board_top i_board_top (
		.clock_50mhz (clock_50mhz), .reset2a_i (reset2a_i),
		.core_ps2_clk_val_i (core_ps2_clk_val_i), .core_ps2_clk_drv_i (core_ps2_clk_drv_i),
		.core_ps2_data_val_i (core_ps2_data_val_i), .core_ps2_data_drv_i (core_ps2_data_drv_i),
		.core_sdc_val_i (core_sdc_val_i), .core_sdc_drv_i (core_sdc_drv_i),
		.core_aud_i (core_aud_i), .status_word_i (status_word_i),
		.ps2_clk_pad_i (ps2_clk_pad), .ps2_data_pad_i (ps2_data_pad), .sdc_dat_pad_i (sdc_pad),
		.core_reset_o (core_reset_o), .ps2_clk_sync_o (ps2_clk_sync_o),
		.ps2_data_sync_o (ps2_data_sync_o), .sdc_dat_sync_o (sdc_dat_sync_o),
		.ps2_clk_oe_o (ps2_clk_oe_o), .ps2_clk_val_o (ps2_clk_val_o),
		.ps2_data_oe_o (ps2_data_oe_o), .ps2_data_val_o (ps2_data_val_o),
		.sdc_oe_o (sdc_oe_o), .sdc_val_o (sdc_val_o), .aud_oe_o (aud_oe_o),
		.seg_char_o (seg_char_o), .seg_seg_o (seg_seg_o)
	);

	// Pad wires, driven value when enabled, else pull-up
	assign ps2_clk_pad = ps2_clk_oe_o ? ps2_clk_val_o : 1'b1;
	assign ps2_data_pad = ps2_data_oe_o ? ps2_data_val_o : 1'b1;
	assign sdc_pad = (sdc_oe_o & sdc_val_o) | ~sdc_oe_o;

	// Release distance, saturates well past the expected fall
	always @(posedge clock_50mhz)
	begin
		if (reset2a_i)
		begin
			since_rel <= 0;
			rst_seen <= 1'b1;
		end
		else if (since_rel < RST_N + 8)
			since_rel <= since_rel + 1;
	end

	task automatic note_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
		$display("ERR %s got %h exp %h at %0t", sig, got, exp, $time);
		errors++;
	endtask

	// Segments for the one selected digit, all off if none
	function automatic logic [7:0] expected_segments(input logic [31:0] word, input logic [7:0] sel);
		logic [7:0] segs;
		segs = 8'hFF;
		for (int d = 0; d < 8; d++)
			if (!sel[d])
				segs = {1'b1, ~SEG_ON[word[4*d +: 4]]};
		return segs;
	endfunction

	a_release: assert property (@(posedge clock_50mhz)
		rst_seen |-> core_reset_o == (since_rel <= RST_N + 3))
		else note_mismatch("core_reset_o", 32'($sampled(core_reset_o)),
			32'($sampled(since_rel) <= RST_N + 3));
	a_reenter: assert property (@(posedge clock_50mhz) reset2a_i |=> core_reset_o)
		else note_mismatch("core_reset_o", 32'($sampled(core_reset_o)), 32'h1);
	a_quiet: assert property (@(posedge clock_50mhz) core_reset_o
		|-> {ps2_clk_oe_o, ps2_data_oe_o, sdc_oe_o, aud_oe_o} == 7'h00)
		else note_mismatch("oe outputs in reset",
			32'($sampled({ps2_clk_oe_o, ps2_data_oe_o, sdc_oe_o, aud_oe_o})), 32'h0);
	a_oe: assert property (@(posedge clock_50mhz) rst_seen && !core_reset_o
		|-> {ps2_clk_oe_o, ps2_data_oe_o, sdc_oe_o}
			== {core_ps2_clk_drv_i, core_ps2_data_drv_i, core_sdc_drv_i})
		else note_mismatch("ps2_clk_oe_o,ps2_data_oe_o,sdc_oe_o",
			32'($sampled({ps2_clk_oe_o, ps2_data_oe_o, sdc_oe_o})),
			32'($sampled({core_ps2_clk_drv_i, core_ps2_data_drv_i, core_sdc_drv_i})));
	a_val: assert property (@(posedge clock_50mhz) rst_seen
		|-> {ps2_clk_val_o, ps2_data_val_o, sdc_val_o}
			== {core_ps2_clk_val_i, core_ps2_data_val_i, core_sdc_val_i})
		else note_mismatch("ps2_clk_val_o,ps2_data_val_o,sdc_val_o",
			32'($sampled({ps2_clk_val_o, ps2_data_val_o, sdc_val_o})),
			32'($sampled({core_ps2_clk_val_i, core_ps2_data_val_i, core_sdc_val_i})));
	// Synced levels trail the wires by SYNC_N edges
	a_sync: assert property (@(posedge clock_50mhz) !reset2a_i && since_rel >= SYNC_N
		|-> {ps2_clk_sync_o, ps2_data_sync_o, sdc_dat_sync_o}
			== $past({ps2_clk_pad, ps2_data_pad, sdc_pad}, SYNC_N))
		else note_mismatch("ps2_clk_sync_o,ps2_data_sync_o,sdc_dat_sync_o",
			32'($sampled({ps2_clk_sync_o, ps2_data_sync_o, sdc_dat_sync_o})),
			32'($past({ps2_clk_pad, ps2_data_pad, sdc_pad}, SYNC_N)));
	a_pullup: assert property (@(posedge clock_50mhz) !reset2a_i && since_rel >= SYNC_N
		&& $past(sdc_oe_o, SYNC_N) == 4'h0 |-> sdc_dat_sync_o == 4'hF)
		else note_mismatch("sdc_dat_sync_o", 32'($sampled(sdc_dat_sync_o)), 32'hF);
	a_audio: assert property (@(posedge clock_50mhz) rst_seen
		|-> aud_oe_o == (!core_aud_i && !core_reset_o))
		else note_mismatch("aud_oe_o", 32'($sampled(aud_oe_o)),
			32'($sampled(!core_aud_i && !core_reset_o)));
	// Display live from the second edge out of core reset
	a_one_low: assert property (@(posedge clock_50mhz) rst_seen && !core_reset_o
		&& $past(!core_reset_o) |-> $onehot(~seg_char_o))
		else note_mismatch("seg_char_o low bits", 32'($sampled(~seg_char_o)), 32'h1);
	a_segments: assert property (@(posedge clock_50mhz) rst_seen && !core_reset_o
		&& $past(!core_reset_o) && $stable(status_word_i)
		|-> seg_seg_o == expected_segments(status_word_i, seg_char_o))
		else note_mismatch("seg_seg_o", 32'($sampled(seg_seg_o)),
			32'(expected_segments($sampled(status_word_i), $sampled(seg_char_o))));

	task automatic drive_random_core;
		logic [31:0] rnd;
		rnd = $random(seed);
		core_ps2_clk_val_i = rnd[0];
		core_ps2_clk_drv_i = rnd[1];
		core_ps2_data_val_i = rnd[2];
		core_ps2_data_drv_i = rnd[3];
		core_sdc_val_i = rnd[7:4];
		core_sdc_drv_i = rnd[11:8];
		core_aud_i = rnd[12];
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start)
			$display("%-22s ok", name);
		else
			$display("%-22s %0d errors", name, errors - errs_at_start);
	endtask

	// Watchdog sized from the reset delay and the display scan
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock_50mhz);
		$display("Timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		reset2a_i = 1'b1;
		status_word_i = '0;
		drive_random_core();
		mark = errors;
		repeat (8)
		begin
			@(negedge clock_50mhz);
			drive_random_core();
		end
		reset2a_i = 1'b0;
		while (core_reset_o) // Random enables through the whole count
		begin
			@(negedge clock_50mhz);
			drive_random_core();
		end
		end_test("drivers off in reset", mark);
		end_test("reset release timing", mark);

		mark = errors;
		repeat (150)
		begin
			@(negedge clock_50mhz);
			drive_random_core();
		end
		repeat (20) // Lines released, pull-up shows
		begin
			@(negedge clock_50mhz);
			drive_random_core();
			core_ps2_clk_drv_i = 1'b0;
			core_ps2_data_drv_i = 1'b0;
			core_sdc_drv_i = '0;
		end
		end_test("pad drive and sync", mark);

		mark = errors;
		repeat (100)
		begin
			@(negedge clock_50mhz);
			drive_random_core();
		end
		end_test("open drain audio", mark);

		mark = errors;
		@(negedge clock_50mhz);
		status_word_i = $random(seed);
		seen = '0;
		repeat (9 * SCAN_DIV)
		begin
			@(negedge clock_50mhz);
			seen = seen | ~seg_char_o;
		end
		assert (seen == 8'hFF)
		else
		begin
			$display("Not every digit was scanned, seen mask %h", seen);
			errors++;
		end
		end_test("display scan", mark);

		mark = errors;
		@(negedge clock_50mhz);
		reset2a_i = 1'b1;
		@(negedge clock_50mhz);
		assert (core_reset_o)
		else
		begin
			$display("Core reset did not rise on the second reset pulse");
			errors++;
		end
		repeat (3) @(negedge clock_50mhz);
		end_test("reset re-entry", mark);

		$display("Tests run %0d, errors %0d", tests_run, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* board_top.f */
+incdir+.
board_pkg.sv
board_ifs.sv
delay_timer.sv
reset_seq_fsm.sv
pad_bank.sv
seg_scanner.sv
board_top.sv
tb_board_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the board shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f board_top.f --top-module tb_board_top \
	--Mdir obj_dir -o tb_board_top

./obj_dir/tb_board_top | tee sim.log

if grep -qx "TEST PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
